// File: design/soc_pkg.sv
// Shared bus types and address map; RAM_WORDS in soc_top must equal the RAM region size
package soc_pkg;

  // Bus word and address types
  typedef logic [15:0] data_t;        // One bus data word
  typedef logic [19:1] addr_t;        // Word address, byte bits 19 to 1
  typedef logic [1:0]  sel_t;         // Byte lane selects
  typedef logic [7:0]  irq_t;         // Interrupt request lines
  typedef logic [2:0]  iid_t;         // Interrupt index

  // Decoded target of a bus cycle
  typedef enum logic [1:0] {
    ram  = 2'd0,
    gpio = 2'd1,
    none = 2'd2                       // Default slave
  } slave_e;

  // Switch cycle state
  typedef enum logic [1:0] {
    idle     = 2'd0,
    wait_ack = 2'd1,
    done     = 2'd2
  } sw_state_e;

  // Regions are compared as {tag, word address}, tag high for I/O space

  // Memory 0x00000 to 0x001FF, 256 words
  localparam logic [19:0] RAM_BASE  = 20'h00000;
  localparam logic [19:0] RAM_MASK  = 20'hFFF00;

  // I/O ports 0xF100 to 0xF103, two words
  localparam logic [19:0] GPIO_BASE = 20'h87880;
  localparam logic [19:0] GPIO_MASK = 20'h87FFE;   // Upper I/O address bits ignored

  // First interrupt vector, line n reads back VECTOR_BASE + n
  localparam data_t VECTOR_BASE  = 16'd8;

  // Read value of an unmapped address
  localparam data_t DEFAULT_READ = 16'hFFFF;

endpackage

// File: design/bus_switch.sv
// Slaves must ack one cycle after their strobe; an unmapped access acks in that same cycle
`timescale 1ns/1ps

module bus_switch (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              cyc_i,
  input  logic              stb_i,
  input  logic              we_i,
  input  logic              tga_i,
  input  soc_pkg::addr_t    adr_i,
  input  soc_pkg::sel_t     sel_i,
  input  soc_pkg::data_t    dat_i,
  output logic              ram_stb_o,
  output logic              gpio_stb_o,
  output logic              we_o,
  output soc_pkg::addr_t    adr_o,
  output soc_pkg::sel_t     sel_o,
  output soc_pkg::data_t    wdat_o,
  input  soc_pkg::data_t    ram_dat_i,
  input  soc_pkg::data_t    gpio_dat_i,
  input  logic              ram_ack_i,
  input  logic              gpio_ack_i,
  output soc_pkg::data_t    dat_o,
  output logic              ack_o
);

  logic                  req;
  logic [19:0]           tagged_adr;
  logic                  ram_hit;
  logic                  gpio_hit;
  logic                  slave_ack;
  soc_pkg::slave_e       live_tgt;
  soc_pkg::slave_e       route_tgt;
  soc_pkg::slave_e       tgt_q;        // Target held for the open cycle
  soc_pkg::sw_state_e    state_q;
  soc_pkg::sw_state_e    state_d;

  assign req        = cyc_i & stb_i;
  assign tagged_adr = {tga_i, adr_i};
  assign ram_hit    = (tagged_adr & soc_pkg::RAM_MASK) == soc_pkg::RAM_BASE;
  assign gpio_hit   = (tagged_adr & soc_pkg::GPIO_MASK) == soc_pkg::GPIO_BASE;

  always_comb begin
    if (ram_hit) begin
      live_tgt = soc_pkg::ram;
    end else if (gpio_hit) begin
      live_tgt = soc_pkg::gpio;
    end else begin
      live_tgt = soc_pkg::none;
    end
  end

  // A new cycle routes on the live decode, an open one on the held target
  assign route_tgt  = (state_q == soc_pkg::wait_ack) ? tgt_q : live_tgt;
  assign ram_stb_o  = req & (route_tgt == soc_pkg::ram);
  assign gpio_stb_o = req & (route_tgt == soc_pkg::gpio);

  assign we_o   = we_i;
  assign adr_o  = adr_i;
  assign sel_o  = sel_i;
  assign wdat_o = dat_i;

  always_comb begin
    case (tgt_q)
      soc_pkg::ram: begin
        slave_ack = ram_ack_i;
        dat_o     = ram_dat_i;
      end
      soc_pkg::gpio: begin
        slave_ack = gpio_ack_i;
        dat_o     = gpio_dat_i;
      end
      default: begin
        slave_ack = 1'b1;                  // Default slave answers at once
        dat_o     = soc_pkg::DEFAULT_READ;
      end
    endcase
  end

  assign ack_o = (state_q == soc_pkg::wait_ack) & slave_ack;  // Stale acks dropped

  always_comb begin
    state_d = state_q;
    case (state_q)
      soc_pkg::idle: begin
        if (req) begin
          state_d = soc_pkg::wait_ack;
        end
      end
      soc_pkg::wait_ack: begin
        if (!cyc_i) begin
          state_d = soc_pkg::idle;         // Master gave up the cycle
        end else if (ack_o) begin
          state_d = soc_pkg::done;
        end
      end
      soc_pkg::done: begin
        if (req) begin
          state_d = soc_pkg::wait_ack;     // Back-to-back strobe
        end else if (!cyc_i) begin
          state_d = soc_pkg::idle;
        end
      end
      default: state_d = soc_pkg::idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= soc_pkg::idle;
      tgt_q   <= soc_pkg::none;
    end else begin
      state_q <= state_d;
      if (req && state_q != soc_pkg::wait_ack) begin
        tgt_q <= live_tgt;                 // Latch decode at strobe start
      end
    end
  end

  // Regions are disjoint and every request decodes to a known target
  a_one_region: assert property (@(posedge clk) disable iff (!rst_n)
    req |-> ($onehot0({ram_hit, gpio_hit}) && !$isunknown(live_tgt)));

  a_ram_ack_stb: assert property (@(posedge clk) disable iff (!rst_n)
    ram_ack_i |-> $past(ram_stb_o));

  a_gpio_ack_stb: assert property (@(posedge clk) disable iff (!rst_n)
    gpio_ack_i |-> $past(gpio_stb_o));

endmodule

// File: design/scratch_ram.sv
// RAM contents start undefined; only the low log2(RAM_WORDS) word address bits are used
`timescale 1ns/1ps

module scratch_ram #(
  parameter int RAM_WORDS = 256
) (
  input  logic              clk,
  input  logic              stb_i,
  input  logic              we_i,
  input  soc_pkg::addr_t    adr_i,
  input  soc_pkg::sel_t     sel_i,
  input  soc_pkg::data_t    dat_i,
  output soc_pkg::data_t    dat_o,
  output logic              ack_o
);

  localparam int IDX_W = $clog2(RAM_WORDS);

  soc_pkg::data_t    mem [RAM_WORDS];
  logic [IDX_W-1:0]  idx;
  logic              access;

  assign idx    = adr_i[IDX_W:1];
  assign access = stb_i & ~ack_o;          // Ignore the strobe still high in the ack cycle

  always_ff @(posedge clk) begin
    if (access && we_i) begin
      if (sel_i[0]) begin
        mem[idx][7:0] <= dat_i[7:0];       // Low byte lane
      end
      if (sel_i[1]) begin
        mem[idx][15:8] <= dat_i[15:8];     // High byte lane
      end
    end
    dat_o <= mem[idx];
  end

  // One-cycle ack per strobe
  always_ff @(posedge clk) begin
    ack_o <= access;
  end

  a_ack_single: assert property (@(posedge clk) ack_o |=> !ack_o);

endmodule

// File: design/gpio_leds.sv
// Word 0 holds the LEDs and word 1 reads the switches, which must already be synchronous
`timescale 1ns/1ps

module gpio_leds (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              stb_i,
  input  logic              we_i,
  input  soc_pkg::addr_t    adr_i,
  input  soc_pkg::sel_t     sel_i,
  input  soc_pkg::data_t    dat_i,
  input  soc_pkg::data_t    sw_i,
  output soc_pkg::data_t    dat_o,
  output logic              ack_o,
  output soc_pkg::data_t    leds_o
);

  logic  access;
  logic  led_wr;

  assign access = stb_i & ~ack_o;
  assign led_wr = access & we_i & ~adr_i[1];   // Word 0 only

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      leds_o <= '0;
      ack_o  <= 1'b0;
    end else begin
      ack_o <= access;
      if (led_wr && sel_i[0]) begin
        leds_o[7:0] <= dat_i[7:0];
      end
      if (led_wr && sel_i[1]) begin
        leds_o[15:8] <= dat_i[15:8];
      end
    end
  end

  // Read data
  always_ff @(posedge clk) begin
    dat_o <= adr_i[1] ? sw_i : leds_o;
  end

endmodule

// File: design/tick_timer.sv
// Needs TIMER_PERIOD >= 2; first pulse comes TIMER_PERIOD cycles after reset release
`timescale 1ns/1ps

module tick_timer #(
  parameter int TIMER_PERIOD = 12500
) (
  input  logic  clk,
  input  logic  rst_n,
  output logic  tick_o
);

  localparam int CNT_W = $clog2(TIMER_PERIOD);

  logic [CNT_W-1:0]  cnt_q;
  logic              wrap;

  assign wrap = (cnt_q == CNT_W'(TIMER_PERIOD - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt_q  <= '0;
      tick_o <= 1'b0;
    end else begin
      tick_o <= wrap;                      // Registered pulse
      if (wrap) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  a_tick_single: assert property (@(posedge clk) disable iff (!rst_n)
    tick_o |=> !tick_o);

endmodule

// File: design/simple_pic.sv
// Lines are edge triggered; a line already high when reset releases raises no request
`timescale 1ns/1ps

module simple_pic (
  input  logic              clk,
  input  logic              rst_n,
  input  soc_pkg::irq_t     irq_i,
  input  logic              inta_i,
  output logic              intr_o,
  output soc_pkg::iid_t     iid_o
);

  localparam int N_IRQ = $bits(soc_pkg::irq_t);

  soc_pkg::irq_t  irq_q;                   // Previous line levels
  soc_pkg::irq_t  pending_q;
  soc_pkg::irq_t  edges;
  soc_pkg::irq_t  clr;

  assign edges = irq_i & ~irq_q;

  // Lowest pending index has the highest priority
  always_comb begin
    iid_o = '0;
    for (int i = N_IRQ - 1; i >= 0; i--) begin
      if (pending_q[i]) begin
        iid_o = soc_pkg::iid_t'(i);
      end
    end
  end

  always_comb begin
    clr = '0;
    if (inta_i) begin
      clr[iid_o] = 1'b1;                   // Served line
    end
  end

  always_ff @(posedge clk) begin
    irq_q <= irq_i;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pending_q <= '0;
    end else begin
      pending_q <= (pending_q & ~clr) | edges;   // New edge beats the clear
    end
  end

  assign intr_o = |pending_q;

  // Master acknowledges only a raised interrupt
  a_inta_intr: assert property (@(posedge clk) disable iff (!rst_n)
    inta_i |-> intr_o);

endmodule

// File: design/soc_top.sv
// Single clock; rst_lck low restarts the reset stretch, which needs DEBOUNCE_CYCLES >= 1
`timescale 1ns/1ps

module soc_top #(
  parameter int DEBOUNCE_CYCLES = 131071,
  parameter int TIMER_PERIOD    = 12500,
  parameter int RAM_WORDS       = 256
) (
  input  logic              clk,
  input  logic              rst_lck,
  input  logic              cyc_i,
  input  logic              stb_i,
  input  logic              we_i,
  input  logic              tga_i,
  input  soc_pkg::addr_t    adr_i,
  input  soc_pkg::sel_t     sel_i,
  input  soc_pkg::data_t    dat_i,
  input  logic              inta_i,
  input  logic [7:1]        irq_i,
  input  soc_pkg::data_t    sw_i,
  output soc_pkg::data_t    dat_o,
  output logic              ack_o,
  output logic              intr_o,
  output soc_pkg::data_t    leds_o
);

  localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

  logic [CNT_W-1:0]  db_cnt_q;
  logic              rst_n;            // Stretched internal reset
  logic              ram_stb;
  logic              gpio_stb;
  logic              bus_we;
  soc_pkg::addr_t    bus_adr;
  soc_pkg::sel_t     bus_sel;
  soc_pkg::data_t    bus_wdat;
  soc_pkg::data_t    ram_dat;
  logic              ram_ack;
  soc_pkg::data_t    gpio_dat;
  logic              gpio_ack;
  soc_pkg::data_t    sw_dat;
  logic              tick;
  soc_pkg::irq_t     irq;
  soc_pkg::iid_t     iid;

  // Reset stays asserted for DEBOUNCE_CYCLES cycles after rst_lck rises
  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      db_cnt_q <= CNT_W'(DEBOUNCE_CYCLES);
      rst_n    <= 1'b0;
    end else begin
      if (db_cnt_q != '0) begin
        db_cnt_q <= db_cnt_q - 1'b1;
      end
      rst_n <= (db_cnt_q <= CNT_W'(1));   // Releases as the count reaches zero
    end
  end

  assign irq = {irq_i, tick};             // Timer owns line 0

  // Vector read during an acknowledge cycle
  assign dat_o = inta_i ? (soc_pkg::VECTOR_BASE + soc_pkg::data_t'(iid)) : sw_dat;

  bus_switch u_bus_switch (
    .clk        (clk),
    .rst_n      (rst_n),
    .cyc_i      (cyc_i),
    .stb_i      (stb_i),
    .we_i       (we_i),
    .tga_i      (tga_i),
    .adr_i      (adr_i),
    .sel_i      (sel_i),
    .dat_i      (dat_i),
    .ram_stb_o  (ram_stb),
    .gpio_stb_o (gpio_stb),
    .we_o       (bus_we),
    .adr_o      (bus_adr),
    .sel_o      (bus_sel),
    .wdat_o     (bus_wdat),
    .ram_dat_i  (ram_dat),
    .gpio_dat_i (gpio_dat),
    .ram_ack_i  (ram_ack),
    .gpio_ack_i (gpio_ack),
    .dat_o      (sw_dat),
    .ack_o      (ack_o)
  );

  scratch_ram #(
    .RAM_WORDS (RAM_WORDS)
  ) u_scratch_ram (
    .clk   (clk),
    .stb_i (ram_stb),
    .we_i  (bus_we),
    .adr_i (bus_adr),
    .sel_i (bus_sel),
    .dat_i (bus_wdat),
    .dat_o (ram_dat),
    .ack_o (ram_ack)
  );

  gpio_leds u_gpio_leds (
    .clk    (clk),
    .rst_n  (rst_n),
    .stb_i  (gpio_stb),
    .we_i   (bus_we),
    .adr_i  (bus_adr),
    .sel_i  (bus_sel),
    .dat_i  (bus_wdat),
    .sw_i   (sw_i),
    .dat_o  (gpio_dat),
    .ack_o  (gpio_ack),
    .leds_o (leds_o)
  );

  tick_timer #(
    .TIMER_PERIOD (TIMER_PERIOD)
  ) u_tick_timer (
    .clk    (clk),
    .rst_n  (rst_n),
    .tick_o (tick)
  );

  simple_pic u_simple_pic (
    .clk    (clk),
    .rst_n  (rst_n),
    .irq_i  (irq),
    .inta_i (inta_i),
    .intr_o (intr_o),
    .iid_o  (iid)
  );

endmodule

// File: test/tb_clock.sv
// Free-running testbench clock, 100 ns period, starts low
`timescale 1ns/1ps

module tb_clock #(
  parameter int HALF_PERIOD = 50
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(HALF_PERIOD) clk_o = ~clk_o;
    end
  end

endmodule

// File: test/soc_checker.sv
// Samples at rising clock edges; TIMER_PERIOD must match the DUT setting
`timescale 1ns/1ps

module soc_checker #(
  parameter int TIMER_PERIOD = 200,
  parameter int ACK_LIMIT    = 4
) (
  input  logic              clk,
  input  logic              cyc_i,
  input  logic              stb_i,
  input  logic              ack_i,
  input  logic              inta_i,
  input  logic              intr_i,
  input  soc_pkg::data_t    dat_i,
  input  soc_pkg::data_t    leds_i,
  input  soc_pkg::data_t    exp_i,
  input  int                test_i,
  input  logic              rd_chk_i,
  input  logic              vec_chk_i,
  input  logic              led_chk_i,
  input  logic              hold_i,
  input  logic              gap_chk_i,
  input  logic              low_chk_i,
  input  logic              end_i,
  output int                checks_o,
  output int                errors_o,
  output int                failed_o,
  output int                tests_o
);

  int    cycle_cnt   = 0;
  int    last_rise   = 0;
  int    stb_age     = 0;
  int    test_checks = 0;
  int    test_errors = 0;
  int    checks      = 0;
  int    errors      = 0;
  int    failed      = 0;
  int    tests       = 0;
  logic  have_rise   = 1'b0;
  logic  intr_q      = 1'b0;       // intr_o at the previous edge

  assign checks_o = checks;
  assign errors_o = errors;
  assign failed_o = failed;
  assign tests_o  = tests;

  function automatic string test_name(input int id);
    case (id)
      1: return "reset_hold";
      2: return "ram_readback";
      3: return "leds_switches";
      4: return "unmapped";
      5: return "timer_irq";
      6: return "irq_priority";
      default: return "unknown";
    endcase
  endfunction

  task automatic report_failure(input string msg);
    test_errors++;
    $display("%s: %s", test_name(test_i), msg);
  endtask

  task automatic check_true(input logic cond, input string msg);
    test_checks++;
    if (cond !== 1'b1) begin
      report_failure(msg);
    end
  endtask

  task automatic compare_word(input string what, input soc_pkg::data_t exp,
                              input soc_pkg::data_t act);
    test_checks++;
    if (act !== exp) begin
      test_errors++;
      $display("** Error %s %s: expected 0x%h, actual 0x%h", test_name(test_i), what, exp, act);
    end
  endtask

  task automatic close_test();
    if (test_checks == 0) begin
      report_failure("no checks were made");
    end
    if (test_errors == 0) begin
      $display("%s: passed, %0d checks", test_name(test_i), test_checks);
    end else begin
      $display("%s: FAILED, %0d errors in %0d checks", test_name(test_i), test_errors,
               test_checks);
      failed++;
    end
    tests++;
    checks      += test_checks;
    errors      += test_errors;
    test_checks = 0;
    test_errors = 0;
  endtask

  always @(posedge clk) begin
    cycle_cnt++;
    if (hold_i) begin
      check_true(!ack_i, "bus ack during the reset hold");
      check_true(leds_i == '0 && !intr_i, "LEDs or interrupt raised during the reset hold");
      stb_age = 0;
    end else if (cyc_i && stb_i) begin
      if (ack_i) begin
        check_true(stb_age == 1,
                   $sformatf("ack came %0d cycles after the strobe instead of 1", stb_age));
        stb_age = 0;                             // Master drops the strobe here
      end else begin
        stb_age++;
        if (stb_age == ACK_LIMIT) begin
          report_failure($sformatf("no ack within %0d cycles of the strobe", ACK_LIMIT));
        end
      end
    end else begin
      stb_age = 0;
    end

    if (rd_chk_i && ack_i) begin
      compare_word("read data", exp_i, dat_i);
    end
    if (vec_chk_i && inta_i) begin
      check_true(intr_i, "acknowledge cycle without a pending interrupt");
      compare_word("vector", exp_i, dat_i);
    end
    if (led_chk_i) begin
      compare_word("leds", exp_i, leds_i);
    end
    if (low_chk_i) begin
      check_true(!intr_i, "interrupt still raised after the last acknowledge");
    end

    // Rises of intr_o, spaced by the timer period when acked at once
    if (intr_i === 1'b1 && intr_q === 1'b0) begin
      if (gap_chk_i && have_rise) begin
        test_checks++;
        if (cycle_cnt - last_rise != TIMER_PERIOD) begin
          test_errors++;
          $display("** Error %s interrupt gap: expected %0d, actual %0d", test_name(test_i),
                   TIMER_PERIOD, cycle_cnt - last_rise);
        end
      end
      have_rise = gap_chk_i;
      last_rise = cycle_cnt;
    end
    if (!gap_chk_i) begin
      have_rise = 1'b0;
    end
    intr_q = intr_i;

    if (end_i) begin
      close_test();
    end
  end

endmodule

// File: test/soc_tb.sv
// Testbench plays the bus master; inputs change 1 ns after the rising edge
`timescale 1ns/1ps

module soc_tb;

  localparam int DEBOUNCE_CYCLES = 16;
  localparam int TIMER_PERIOD    = 200;
  localparam int ACK_WAIT        = 8;
  localparam int INTR_WAIT       = TIMER_PERIOD + 8;
  localparam int N_TESTS         = 6;
  localparam int BUDGET = (16 + DEBOUNCE_CYCLES) + 192 * 3 + 40 + 48 + 5 * TIMER_PERIOD + 24;
  localparam int MAX_CYCLES      = 2 * BUDGET;

  localparam int TGT_RAM  = 0;
  localparam int TGT_LED  = 1;
  localparam int TGT_SW   = 2;
  localparam int TGT_NONE = 3;

  logic              clk;
  logic              rst_lck;
  logic              cyc;
  logic              stb;
  logic              we;
  logic              tga;
  soc_pkg::addr_t    adr;
  soc_pkg::sel_t     sel;
  soc_pkg::data_t    wdat;
  logic              inta;
  logic [7:1]        irq_lines;
  soc_pkg::data_t    sw;
  soc_pkg::data_t    rdat;
  logic              ack;
  logic              intr;
  soc_pkg::data_t    leds;

  soc_pkg::data_t    exp_data;
  int                test_id;
  logic              rd_chk;
  logic              vec_chk;
  logic              led_chk;
  logic              hold;
  logic              gap_chk;
  logic              low_chk;
  logic              end_flag;
  int                checks;
  int                errors;
  int                failed;
  int                tests;
  int                cycle_count = 0;
  int                seed = 64225;

  soc_pkg::data_t    ram_model [256];     // Reference copy of the scratch RAM
  soc_pkg::data_t    led_model;
  soc_pkg::data_t    sw_model;

  tb_clock u_tb_clock (.clk_o(clk));

  soc_top #(
    .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
    .TIMER_PERIOD    (TIMER_PERIOD),
    .RAM_WORDS       (256)
  ) u_soc_top (
    .clk (clk), .rst_lck (rst_lck), .cyc_i (cyc), .stb_i (stb), .we_i (we), .tga_i (tga),
    .adr_i (adr), .sel_i (sel), .dat_i (wdat), .inta_i (inta), .irq_i (irq_lines),
    .sw_i (sw), .dat_o (rdat), .ack_o (ack), .intr_o (intr), .leds_o (leds)
  );

  soc_checker #(
    .TIMER_PERIOD (TIMER_PERIOD)
  ) u_soc_checker (
    .clk (clk), .cyc_i (cyc), .stb_i (stb), .ack_i (ack), .inta_i (inta), .intr_i (intr),
    .dat_i (rdat), .leds_i (leds), .exp_i (exp_data), .test_i (test_id),
    .rd_chk_i (rd_chk), .vec_chk_i (vec_chk), .led_chk_i (led_chk), .hold_i (hold),
    .gap_chk_i (gap_chk), .low_chk_i (low_chk), .end_i (end_flag),
    .checks_o (checks), .errors_o (errors), .failed_o (failed), .tests_o (tests)
  );

  // Target of a byte address by the system's address map
  function automatic int target_of(input logic io, input logic [19:0] badr);
    if (!io && badr < 20'h00200) begin
      return TGT_RAM;
    end
    if (io && badr[15:2] == 14'h3C40) begin  // Ports 0xF100 to 0xF103
      return badr[1] ? TGT_SW : TGT_LED;
    end
    return TGT_NONE;
  endfunction

  function automatic soc_pkg::data_t merge_lanes(input soc_pkg::data_t old,
                                                 input soc_pkg::data_t nval,
                                                 input soc_pkg::sel_t lanes);
    soc_pkg::data_t res;
    res = old;
    if (lanes[0]) begin
      res[7:0] = nval[7:0];
    end
    if (lanes[1]) begin
      res[15:8] = nval[15:8];
    end
    return res;
  endfunction

  // Reference read value
  function automatic soc_pkg::data_t expected_read(input logic io, input logic [19:0] badr);
    case (target_of(io, badr))
      TGT_RAM: return ram_model[badr[8:1]];
      TGT_LED: return led_model;
      TGT_SW:  return sw_model;
      default: return soc_pkg::DEFAULT_READ;
    endcase
  endfunction

  function automatic soc_pkg::data_t rand_word();
    return soc_pkg::data_t'($random(seed));
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic run_cycle(input logic io, input logic [19:0] badr, input logic wr,
                           input soc_pkg::sel_t lanes, input soc_pkg::data_t data);
    int waited;
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = wr;
    tga   = io;
    adr   = badr[19:1];
    sel   = lanes;
    wdat  = data;
    waited = 0;
    do begin
      next_cycle();
      waited++;
    end while (!ack && waited < ACK_WAIT);   // Missing ack is flagged by the checker
    next_cycle();                              // Edge that samples the ack
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
  endtask

  task automatic bus_write(input logic io, input logic [19:0] badr,
                           input soc_pkg::sel_t lanes, input soc_pkg::data_t data);
    case (target_of(io, badr))
      TGT_RAM: ram_model[badr[8:1]] = merge_lanes(ram_model[badr[8:1]], data, lanes);
      TGT_LED: led_model = merge_lanes(led_model, data, lanes);
      default: ;                               // Switch word and unmapped writes do nothing
    endcase
    run_cycle(io, badr, 1'b1, lanes, data);
  endtask

  task automatic bus_read(input logic io, input logic [19:0] badr);
    exp_data = expected_read(io, badr);
    rd_chk   = 1'b1;
    run_cycle(io, badr, 1'b0, 2'b11, '0);
    rd_chk   = 1'b0;
  endtask

  task automatic check_leds();
    exp_data = led_model;
    led_chk  = 1'b1;
    next_cycle();
    led_chk  = 1'b0;
  endtask

  task automatic wait_intr();
    int waited;
    waited = 0;
    while (!intr && waited < INTR_WAIT) begin
      next_cycle();
      waited++;
    end
  endtask

  // One acknowledge cycle; lowest pending line wins
  task automatic ack_vector(input int line);
    exp_data = soc_pkg::VECTOR_BASE + soc_pkg::data_t'(line);
    inta     = 1'b1;
    vec_chk  = 1'b1;
    next_cycle();
    inta     = 1'b0;
    vec_chk  = 1'b0;
  endtask

  task automatic start_test(input int id);
    test_id = id;
  endtask

  task automatic end_test();
    end_flag = 1'b1;
    next_cycle();
    end_flag = 1'b0;
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Run stopped after %0d cycles without finishing", MAX_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    int r;
    rst_lck   = 1'b0;
    cyc       = 1'b0;
    stb       = 1'b0;
    we        = 1'b0;
    tga       = 1'b0;
    adr       = '0;
    sel       = '0;
    wdat      = '0;
    inta      = 1'b0;
    irq_lines = '0;
    sw        = '0;
    exp_data  = '0;
    test_id   = 0;
    rd_chk    = 1'b0;
    vec_chk   = 1'b0;
    led_chk   = 1'b0;
    hold      = 1'b0;
    gap_chk   = 1'b0;
    low_chk   = 1'b0;
    end_flag  = 1'b0;
    led_model = '0;
    sw_model  = '0;
    repeat (8) next_cycle();
    rst_lck = 1'b1;

    // Read held open during the debounce stretch
    start_test(1);
    hold = 1'b1;
    cyc = 1'b1;
    stb = 1'b1;
    sel = 2'b11;
    repeat (6) next_cycle();
    cyc = 1'b0;
    stb = 1'b0;
    repeat (DEBOUNCE_CYCLES - 7) next_cycle();
    hold = 1'b0;
    repeat (4) next_cycle();
    end_test();

    start_test(2);
    for (int i = 0; i < 64; i++) bus_write(1'b0, 20'(i * 8), 2'b11, rand_word());
    for (int i = 0; i < 64; i++) begin
      r = $random(seed);
      bus_write(1'b0, 20'((r & 63) * 8), soc_pkg::sel_t'(r >> 8), rand_word());
    end
    for (int i = 0; i < 64; i++) bus_read(1'b0, 20'(i * 8));
    end_test();

    start_test(3);
    sw_model = rand_word();
    sw = sw_model;
    bus_write(1'b1, 20'hF100, 2'b11, rand_word());
    check_leds();
    bus_write(1'b1, 20'hF100, 2'b10, rand_word());    // High byte only
    check_leds();
    bus_read(1'b1, 20'hF100);
    bus_read(1'b1, 20'hF102);
    end_test();

    start_test(4);
    bus_read(1'b0, 20'h00400);
    bus_read(1'b0, 20'h0F100);                        // Memory space, not the LED port
    bus_read(1'b1, 20'h00060);
    bus_write(1'b0, 20'h00400, 2'b11, rand_word());  // Would alias RAM word 0
    bus_write(1'b1, 20'h00060, 2'b11, rand_word());
    bus_write(1'b1, 20'hF102, 2'b11, rand_word());
    bus_read(1'b0, 20'h00000);
    bus_read(1'b1, 20'hF100);
    check_leds();
    end_test();

    start_test(5);
    gap_chk = 1'b1;
    repeat (4) begin
      wait_intr();
      ack_vector(0);
    end
    gap_chk = 1'b0;
    end_test();

    start_test(6);
    irq_lines[3] = 1'b1;
    irq_lines[5] = 1'b1;
    wait_intr();
    ack_vector(3);
    ack_vector(5);
    low_chk = 1'b1;
    next_cycle();
    low_chk = 1'b0;
    irq_lines = '0;
    end_test();

    repeat (2) next_cycle();
    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests, failed, checks, errors);
    if (errors == 0 && failed == 0 && tests == N_TESTS) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: verilog.f
design/soc_pkg.sv
design/bus_switch.sv
design/scratch_ram.sv
design/gpio_leds.sv
design/tick_timer.sv
design/simple_pic.sv
design/soc_top.sv
test/tb_clock.sv
test/soc_checker.sv
test/soc_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = soc_tb
FILE_LIST = verilog.f
PASS_TEXT = Test completed successfully

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST)
	./obj_dir/V$(TOP) | awk '{ print } $$0 == "$(PASS_TEXT)" { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
